//--- flit_counter.sv
// Flit position counter
// Tracks which flit of the current word is on the link and flags the
// last one. Advances on every flit handshake while a word is being sent

`timescale 1ns/1ps
`default_nettype none

module flit_counter (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               sending,
  input  wire logic                               flit_fire,
  output logic      [link_pkg::flit_id_width-1:0] flit_id,
  output logic                                    flit_last
);

  // Id of the last flit, sized to the counter
  localparam logic [link_pkg::flit_id_width-1:0] last_id =
    link_pkg::flit_id_width'(link_pkg::last_flit_id);

  logic [link_pkg::flit_id_width-1:0] count;
  logic                               advance;

  // Only a completed flit handshake during a send moves the position
  assign advance = sending && flit_fire;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (advance) begin
      // Wrap back to the first flit once the last one has gone out
      if (count == last_id) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign flit_id   = count;
  // The last flag is decoded from the count, so it always agrees with the id
  assign flit_last = (count == last_id);

endmodule

`default_nettype wire

//--- flit_link_properties.sv
// Flit link properties
// Concurrent checks on the flit side and the word side of the
// deserializer, attached to every instance of it by bind

`timescale 1ns/1ps
`default_nettype none

module flit_link_properties (
  input wire logic                               clk,
  input wire logic                               reset,
  input wire logic                               flit_valid,
  input wire logic [link_pkg::flit_id_width-1:0] flit_id,
  input wire logic                               flit_last,
  input wire logic                               out_valid,
  input wire logic                               out_ready,
  input wire logic [link_pkg::word_width-1:0]    out_data
);

  // Id of the flit that closes a word
  localparam logic [link_pkg::flit_id_width-1:0] last_id =
    link_pkg::flit_id_width'(link_pkg::last_flit_id);

  // Every flit on the link names a position inside the word
  id_in_range: assert property (@(posedge clk) disable iff (reset)
    flit_valid |-> (int'(flit_id) < link_pkg::num_flits))
    else $error("flit id outside the word");

  // The last flag travels with the final flit id
  last_on_last_id: assert property (@(posedge clk) disable iff (reset)
    (flit_valid && flit_id == last_id) |-> flit_last)
    else $error("final flit id without the last flag");

  // A word is only offered while the last flit sits on the link
  out_needs_last: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> (flit_valid && flit_last))
    else $error("out_valid without the last flit");

  // A refused word stays on the port unchanged
  out_stable: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("output word changed while stalled");

endmodule

`default_nettype wire

//--- flit_link_top.sv
// Flit link top level
// Splits 32-bit input words into four 8-bit flits and rebuilds them on
// the far side. Ready-valid on the input and on the output

`timescale 1ns/1ps
`default_nettype none

module flit_link_top (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            in_valid,
  output logic                                 in_ready,
  input  wire logic [link_pkg::word_width-1:0] in_data,
  output logic                                 out_valid,
  input  wire logic                            out_ready,
  output logic      [link_pkg::word_width-1:0] out_data
);

  // -------------------------------------------------------------------
  // Internal wires
  // -------------------------------------------------------------------

  // Serializer control
  logic                               load;
  logic                               sending;
  logic                               flit_fire;
  logic [link_pkg::flit_id_width-1:0] cnt_flit_id;
  logic                               cnt_flit_last;

  // Internal flit link
  logic                               flit_valid;
  logic                               flit_ready;
  logic [link_pkg::flit_width-1:0]    flit_data;
  logic [link_pkg::flit_id_width-1:0] flit_id;
  logic                               flit_last;

  // -------------------------------------------------------------------
  // Serializer side
  // -------------------------------------------------------------------

  serializer_fsm u_serializer_fsm (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .flit_fire (flit_fire),
    .flit_last (cnt_flit_last),
    .load      (load),
    .sending   (sending)
  );

  flit_counter u_flit_counter (
    .clk       (clk),
    .reset     (reset),
    .sending   (sending),
    .flit_fire (flit_fire),
    .flit_id   (cnt_flit_id),
    .flit_last (cnt_flit_last)
  );

  word_serializer u_word_serializer (
    .clk           (clk),
    .reset         (reset),
    .load          (load),
    .in_data       (in_data),
    .sending       (sending),
    .flit_id       (cnt_flit_id),
    .flit_last     (cnt_flit_last),
    .flit_ready    (flit_ready),
    .flit_valid    (flit_valid),
    .flit_data     (flit_data),
    .flit_id_out   (flit_id),
    .flit_last_out (flit_last),
    .flit_fire     (flit_fire)
  );

  // -------------------------------------------------------------------
  // Deserializer side
  // -------------------------------------------------------------------

  flow_deserializer u_flow_deserializer (
    .clk        (clk),
    .reset      (reset),
    .flit_valid (flit_valid),
    .flit_ready (flit_ready),
    .flit_data  (flit_data),
    .flit_id    (flit_id),
    .flit_last  (flit_last),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

endmodule

`default_nettype wire

//--- flow_deserializer.sv
// Flow deserializer
// Collects the flits of a word into per-slot registers by flit id and
// passes the last flit straight through, so the assembled word is popped
// on the same cycle the last flit arrives. Ready-valid on both sides

`timescale 1ns/1ps
`default_nettype none

module flow_deserializer (
  input  wire logic                               clk,
  input  wire logic                               reset,

  // Narrow side, one flit per handshake
  input  wire logic                               flit_valid,
  output logic                                    flit_ready,
  input  wire logic [link_pkg::flit_width-1:0]    flit_data,
  input  wire logic [link_pkg::flit_id_width-1:0] flit_id,
  input  wire logic                               flit_last,

  // Wide side, one assembled word per handshake
  output logic                                    out_valid,
  input  wire logic                               out_ready,
  output logic      [link_pkg::word_width-1:0]    out_data
);

  // Number of flits that are held in registers
  localparam int num_slots = link_pkg::last_flit_id;

  // -------------------------------------------------------------------
  // Slot storage
  // -------------------------------------------------------------------

  logic [link_pkg::flit_width-1:0] slot_data [num_slots];
  logic [num_slots-1:0]            slot_valid;

  // One-hot slot selection decoded from the flit id
  logic [num_slots-1:0]            slot_sel;
  // Slots written on this cycle
  logic [num_slots-1:0]            slot_write;
  logic                            slots_full;
  logic                            out_fire;

  // -------------------------------------------------------------------
  // Flit demultiplexing
  // -------------------------------------------------------------------

  // The last flag steers a flit to the pass-through path and the id
  // picks the slot for every other flit
  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      slot_sel[i]   = !flit_last && (flit_id == link_pkg::flit_id_width'(i));
      slot_write[i] = flit_valid && slot_sel[i] && !slot_valid[i];
    end
  end

  assign slots_full = &slot_valid;

  // A stored flit is accepted when its slot is empty
  // The last flit can only move together with the whole word
  assign flit_ready = flit_last ? (out_ready && slots_full) : |(slot_sel & ~slot_valid);

  // -------------------------------------------------------------------
  // Output side
  // -------------------------------------------------------------------

  // Combinational path from the last flit to the output
  assign out_valid = flit_valid && flit_last && slots_full;
  assign out_fire  = out_valid && out_ready;

  // Slot 0 lands in the top bits and the pass-through flit in the bottom
  always_comb begin
    out_data[link_pkg::flit_width-1:0] = flit_data;
    for (int i = 0; i < num_slots; i++) begin
      out_data[(num_slots - i) * link_pkg::flit_width +: link_pkg::flit_width] = slot_data[i];
    end
  end

  // -------------------------------------------------------------------
  // Slot state
  // -------------------------------------------------------------------

  // Popping the word empties every slot at once
  // A pop and a slot write never share a cycle since one needs the last
  // flag and the other needs it low
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid <= '0;
    end else if (out_fire) begin
      slot_valid <= '0;
    end else begin
      slot_valid <= slot_valid | slot_write;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_slots; i++) begin
      if (slot_write[i]) begin
        slot_data[i] <= flit_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- link_pkg.sv
// Flit link package
// Widths and flit counts shared by the serializer, the deserializer and
// the testbench of the 32-bit over 8-bit flit link

`default_nettype none

package link_pkg;

  // -------------------------------------------------------------------
  // Link geometry
  // -------------------------------------------------------------------

  // Width of a word on the input and output ports
  localparam int word_width = 32;

  // Width of one flit on the internal link
  localparam int flit_width = 8;

  // Number of flits needed to carry one word
  localparam int num_flits = word_width / flit_width;

  // Bits needed to number every flit of a word
  localparam int flit_id_width = $clog2(num_flits);

  // Id of the final flit of a word, which is the one the deserializer
  // passes straight through
  localparam int last_flit_id = num_flits - 1;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the flit link testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_flit_link \
  -o tb_flit_link \
  && ./obj_dir/tb_flit_link 2>&1 | tee sim.log \
  || echo "build or simulation did not complete"

grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

//--- serializer_fsm.sv
// Serializer control
// Two-state machine (idle, send) that accepts input words and keeps the
// link busy until the last flit of each word has been handed over

`timescale 1ns/1ps
`default_nettype none

module serializer_fsm (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic in_valid,
  output logic      in_ready,
  input  wire logic flit_fire,
  input  wire logic flit_last,
  output logic      load,
  output logic      sending
);

  // -------------------------------------------------------------------
  // State
  // -------------------------------------------------------------------

  // One state bit is enough for two states
  // Low means idle and high means send
  logic state_send;
  logic last_done;

  // The final flit of the current word completes its handshake this cycle
  assign last_done = state_send && flit_fire && flit_last;

  // -------------------------------------------------------------------
  // Input handshake
  // -------------------------------------------------------------------

  // Ready in idle, and also on the cycle the last flit leaves so that
  // back-to-back words follow each other without a bubble
  assign in_ready = !state_send || last_done;

  // A word is captured whenever the input handshake completes
  assign load = in_valid && in_ready;

  // -------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_send <= 1'b0;
    end else if (load) begin
      // A newly accepted word always starts (or continues) a send
      state_send <= 1'b1;
    end else if (last_done) begin
      // Word finished and nothing new is waiting
      state_send <= 1'b0;
    end
  end

  assign sending = state_send;

endmodule

`default_nettype wire

//--- tb.f
link_pkg.sv
flit_counter.sv
serializer_fsm.sv
word_serializer.sv
flow_deserializer.sv
flit_link_top.sv
flit_link_properties.sv
tb_flit_link.sv

//--- tb_flit_link.sv
// Flit link testbench
// Applies a table of words with out_ready stall patterns, then random words
// under random back-pressure, and checks order, latency and throughput of
// the rebuilt words against a scoreboard of accepted input words

`timescale 1ns/1ps
`default_nettype none

module tb_flit_link;

  // ----------------------------------------------------------------------
  // Test sizing
  // ----------------------------------------------------------------------

  localparam int reset_cycles = 10;
  localparam int table_len = 12;
  localparam int random_words = 20;
  // Longest run of low out_ready cycles that the driver allows
  localparam int max_stall = 4;
  // The table is applied twice, first without stalls and then with them
  localparam int num_words = 2 * table_len + random_words;
  localparam int timeout_cycles = reset_cycles + num_words * (4 + max_stall) + 50;

  logic                            clk;
  logic                            reset;
  logic                            in_valid;
  logic                            in_ready;
  logic [link_pkg::word_width-1:0] in_data;
  logic                            out_valid;
  logic                            out_ready;
  logic [link_pkg::word_width-1:0] out_data;

  // Input words and their out_ready patterns
  // Bit 0 of a pattern is applied first
  logic [link_pkg::word_width-1:0] table_word [table_len] = '{
    32'h01234567, 32'h89abcdef, 32'hffffffff, 32'h00000000,
    32'h80000001, 32'hdeadbeef, 32'hcafef00d, 32'h5a5aa5a5,
    32'h0f0f0f0f, 32'hf0e1d2c3, 32'h7fffffff, 32'h13579bdf
  };
  logic [7:0] table_stall [table_len] = '{
    8'hff, 8'h7e, 8'hee, 8'haa, 8'hf0, 8'h0f,
    8'h81, 8'hcc, 8'h3c, 8'h55, 8'he1, 8'h18
  };

  // Scoreboard of accepted words and the cycle each was accepted in
  logic [link_pkg::word_width-1:0] expected_q [$];
  int                              accept_q [$];

  int                              cycle;
  int                              errors;
  int                              checks;
  int                              tests;
  int                              last_accept;
  bit                              timing_checks;
  bit                              stall_seen;
  logic [link_pkg::word_width-1:0] stall_data;
  logic [31:0]                     lcg_state;
  int                              zero_run;

  flit_link_top DUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  // Interface checks live inside the deserializer instance
  bind flow_deserializer flit_link_properties u_properties (
    .clk        (clk),
    .reset      (reset),
    .flit_valid (flit_valid),
    .flit_id    (flit_id),
    .flit_last  (flit_last),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_word(input string what, input logic [link_pkg::word_width-1:0] got,
                            input logic [link_pkg::word_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Mode 0 keeps out_ready high, mode 1 follows a pattern, mode 2 is random
  task automatic drive_ready(input int mode, input logic [7:0] pattern, input int k);
    logic r;
    r = 1'b1;
    if (mode == 1) begin
      r = pattern[k[2:0]];
    end else if (mode == 2) begin
      lcg_state = lcg_next(lcg_state);
      r = (lcg_state[17:16] != 2'b00);
    end
    // A capped stall keeps every word moving within a known time
    if (!r && zero_run >= max_stall) begin
      r = 1'b1;
    end
    zero_run = r ? 0 : zero_run + 1;
    out_ready = r;
  endtask

  // Offers one word and returns just after the edge that accepted it
  task automatic send_word(input logic [link_pkg::word_width-1:0] word, input int mode,
                           input logic [7:0] pattern);
    bit taken;
    int k;
    taken = 1'b0;
    k = 0;
    in_valid = 1'b1;
    in_data = word;
    while (!taken) begin
      drive_ready(mode, pattern, k);
      k++;
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #1;
    end
  endtask

  // Stops offering words and waits until every accepted word came out
  task automatic drain(input int mode);
    int k;
    k = 0;
    in_valid = 1'b0;
    while (expected_q.size() != 0) begin
      drive_ready(mode, 8'hff, k);
      k++;
      @(posedge clk);
      #1;
    end
    out_ready = 1'b1;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitor and scoreboard sampled at the falling edge
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    cycle++;
    if (cycle >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $finish;
    end else if (!reset) begin
      // A word that was refused last cycle must still be offered unchanged
      if (stall_seen) begin
        check_bit("out_valid held during stall", out_valid, 1'b1);
        check_word("out_data held during stall", out_data, stall_data);
      end
      if (in_valid && in_ready) begin
        if (timing_checks && last_accept >= 0) begin
          check_count("cycles between accepted words", cycle - last_accept, 4);
        end
        expected_q.push_back(in_data);
        accept_q.push_back(cycle);
        last_accept = cycle;
      end
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          errors++;
          $display("Error at %0t ns: a word came out with no accepted word pending", $time);
        end else begin
          check_word("output word", out_data, expected_q.pop_front());
          if (timing_checks) begin
            check_count("cycles from accept to out_valid", cycle - accept_q[0], 4);
          end
          void'(accept_q.pop_front());
        end
      end
      stall_seen = out_valid && !out_ready;
      stall_data = out_data;
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int                              errors_before;
    logic [link_pkg::word_width-1:0] word;
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b1;
    cycle = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    last_accept = -1;
    timing_checks = 1'b0;
    stall_seen = 1'b0;
    stall_data = '0;
    lcg_state = 32'hc49b;
    zero_run = 0;

    // Idle outputs during and right after reset
    errors_before = errors;
    repeat (reset_cycles) begin
      @(negedge clk);
      check_bit("out_valid during reset", out_valid, 1'b0);
      check_bit("in_ready during reset", in_ready, 1'b1);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_bit("out_valid after reset", out_valid, 1'b0);
    check_bit("in_ready after reset", in_ready, 1'b1);
    @(posedge clk);
    #1;
    finish_test("reset", errors_before);

    // Back to back words with no back-pressure, so timing is exact
    errors_before = errors;
    timing_checks = 1'b1;
    last_accept = -1;
    for (int i = 0; i < table_len; i++) begin
      send_word(table_word[i], 0, 8'hff);
    end
    drain(0);
    timing_checks = 1'b0;
    finish_test("order_latency_throughput", errors_before);

    errors_before = errors;
    for (int i = 0; i < table_len; i++) begin
      send_word(table_word[i], 1, table_stall[i]);
    end
    drain(1);
    finish_test("table_backpressure", errors_before);

    errors_before = errors;
    for (int i = 0; i < random_words; i++) begin
      lcg_state = lcg_next(lcg_state);
      word = lcg_state;
      send_word(word, 2, 8'h00);
    end
    drain(2);
    finish_test("random_backpressure", errors_before);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- word_serializer.sv
// Word serializer datapath
// Holds the accepted word and drives one flit of it per handshake onto
// the internal link, most significant flit first, with id and last flag

`timescale 1ns/1ps
`default_nettype none

module word_serializer (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               load,
  input  wire logic [link_pkg::word_width-1:0]    in_data,
  input  wire logic                               sending,
  input  wire logic [link_pkg::flit_id_width-1:0] flit_id,
  input  wire logic                               flit_last,
  input  wire logic                               flit_ready,
  output logic                                    flit_valid,
  output logic      [link_pkg::flit_width-1:0]    flit_data,
  output logic      [link_pkg::flit_id_width-1:0] flit_id_out,
  output logic                                    flit_last_out,
  output logic                                    flit_fire
);

  // Word currently being sent
  logic [link_pkg::word_width-1:0] word_q;

  // Bit offset of the selected flit within the held word
  int unsigned flit_lsb;

  // Loaded on every accepted input word
  always_ff @(posedge clk) begin
    if (reset) begin
      word_q <= '0;
    end else if (load) begin
      word_q <= in_data;
    end
  end

  // Flit 0 sits in the top bits, so the offset counts down as the id rises
  assign flit_lsb  = (link_pkg::last_flit_id - int'(flit_id)) * link_pkg::flit_width;
  assign flit_data = word_q[flit_lsb +: link_pkg::flit_width];

  // The link carries a flit whenever a word is in flight
  assign flit_valid = sending;

  // Sideband travels alongside the data
  assign flit_id_out   = flit_id;
  assign flit_last_out = flit_last;

  // Single link handshake, shared by the counter and the state machine
  assign flit_fire = flit_valid && flit_ready;

endmodule

`default_nettype wire
